// File: verilog/tcp_pkg.sv
`default_nettype none

package tcp_pkg;

  typedef enum logic [2:0] {
    st_closed,
    st_listen,
    st_syn_received,
    st_wait_syn_ack,
    st_established,
    st_send_fin,
    st_send_ack,
    st_last_ack
  } tcp_state_t;

  typedef enum logic [1:0] {
    close_active,   // user drop or force_fin
    close_passive,  // remote FIN
    close_reset     // remote RST, nothing sent
  } close_t;

  typedef enum logic [2:0] {
    req_none,
    req_syn,
    req_syn_ack,
    req_ack,
    req_psh_ack,
    req_fin_ack
  } tx_req_t;

  // flag bits in header order, ns is the msb
  typedef struct packed {
    logic ns;
    logic cwr;
    logic ece;
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flag_bits_t;

  typedef union packed {
    logic [8:0]     word;
    tcp_flag_bits_t bits;
  } tcp_flags_u;

  typedef struct packed {
    logic [31:0] ipv4;
    logic [15:0] port;
    logic [31:0] loc_seq;
    logic [31:0] loc_ack;
    logic [31:0] rem_seq;
    logic [31:0] rem_ack;
  } tcb_t;

  localparam logic [8:0] FLAGS_SYN     = 9'h002;
  localparam logic [8:0] FLAGS_SYN_ACK = 9'h012;
  localparam logic [8:0] FLAGS_ACK     = 9'h010;
  localparam logic [8:0] FLAGS_PSH_ACK = 9'h018;
  localparam logic [8:0] FLAGS_FIN_ACK = 9'h011;

  // fixed initial sequence numbers
  localparam logic [31:0] ISN_ACTIVE  = 32'habbadead;
  localparam logic [31:0] ISN_PASSIVE = 32'hfeadabba;

endpackage

`default_nettype wire

// File: verilog/tcp_seg_if.sv
`timescale 1ns/10ps
`default_nettype none

// one tcp header, valid only while hdr_v is high
interface tcp_seg_if import tcp_pkg::*; ();

  logic        hdr_v;
  logic [15:0] src_port;
  logic [15:0] dst_port;
  logic [31:0] seq;
  logic [31:0] ack;
  tcp_flags_u  flags;
  logic [15:0] payload_len;
  logic [31:0] ipv4;         // remote side address

  modport src (
    output hdr_v, src_port, dst_port, seq, ack, flags, payload_len, ipv4
  );

  modport dst (
    input hdr_v, src_port, dst_port, seq, ack, flags, payload_len, ipv4
  );

endinterface

`default_nettype wire

// File: verilog/tcp_rx_filter.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_rx_filter (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic        rx_hdr_v,
  input  logic [31:0] rx_src_ip,
  input  logic [15:0] rx_src_port,
  input  logic [15:0] rx_dst_port,
  input  logic [31:0] rx_seq,
  input  logic [31:0] rx_ack,
  input  logic [8:0]  rx_flags,
  input  logic [15:0] rx_payload_len,
  input  logic        rx_v,
  input  logic [7:0]  rx_d,
  input  logic [15:0] local_port,
  input  logic [15:0] tcb_port,
  input  logic [31:0] tcb_loc_ack,
  input  logic        established,
  tcp_seg_if.src      seg,
  output logic        in_order,
  output logic        vout,
  output logic [7:0]  dout
);

  logic       match;
  logic       pass_q;  // in-order result of the latest header
  logic [1:0] v_pipe;
  logic [7:0] d1;
  logic [7:0] d2;

  // in-order data for this connection only
  assign match = rx_hdr_v && established &&
                 (rx_dst_port == local_port) &&
                 (rx_src_port == tcb_port) &&
                 (rx_seq == tcb_loc_ack);

  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      seg.hdr_v <= 1'b0;
      in_order  <= 1'b0;
      pass_q    <= 1'b0;
      v_pipe    <= '0;
    end else begin
      seg.hdr_v <= rx_hdr_v;
      in_order  <= match;
      v_pipe    <= {v_pipe[0], rx_v};
      if (seg.hdr_v) pass_q <= in_order;  // holds until the next header
    end
  end

  // header and byte payload
  always_ff @(posedge clk) begin
    if (rx_hdr_v) begin
      seg.src_port    <= rx_src_port;
      seg.dst_port    <= rx_dst_port;
      seg.seq         <= rx_seq;
      seg.ack         <= rx_ack;
      seg.flags.word  <= rx_flags;
      seg.payload_len <= rx_payload_len;
      seg.ipv4        <= rx_src_ip;
    end
    d1 <= rx_d;
    d2 <= d1;
  end

  assign vout = v_pipe[1] && pass_q;
  assign dout = d2;

endmodule

`default_nettype wire

// File: verilog/tcp_ack_timer.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_ack_timer #(
  parameter int ACK_TIMEOUT = 125000
) (
  input  logic   clk,
  input  logic   tcp_rst,
  input  logic   established,
  tcp_seg_if.dst seg,
  input  logic   in_order,
  output logic   ack_due
);

  localparam int CW = $clog2(ACK_TIMEOUT + 1);
  localparam logic [CW-1:0] CNT_LAST = CW'(ACK_TIMEOUT - 1);
  localparam logic [CW-1:0] CNT_FULL = CW'(ACK_TIMEOUT);

  logic [CW-1:0] cnt;
  logic          data_accepted;

  // zero-length segments don't restart the timer
  assign data_accepted = seg.hdr_v && in_order && (seg.payload_len != '0);

  always_ff @(posedge clk) begin
    if (tcp_rst || !established) begin
      cnt     <= '0;
      ack_due <= 1'b0;
    end else begin
      ack_due <= !data_accepted && (cnt == CNT_LAST);
      if (data_accepted) cnt <= '0;
      else if (cnt != CNT_FULL) cnt <= cnt + 1'b1;  // saturate, one strobe only
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcp_conn_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_conn_fsm import tcp_pkg::*; #(
  parameter int CONN_TIMEOUT_TICKS = 10000000
) (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic        listen,
  input  logic        connect,
  input  logic        force_fin,
  input  logic [31:0] rem_ipv4,
  input  logic [15:0] rem_port,
  input  logic [15:0] local_port,
  tcp_seg_if.dst      seg,
  input  logic        in_order,
  input  logic        ack_due,
  input  logic        queue_pend,
  input  logic [31:0] queue_seq,
  input  logic [15:0] queue_len,
  input  logic        queue_flushed,
  input  logic        tx_done,
  output tcb_t        tcb,
  output tx_req_t     tx_req,
  output logic [31:0] tx_seq,
  output logic [15:0] tx_len,
  output logic        flush_queue,
  output logic        connected,
  output logic        established
);

  localparam int TW = $clog2(CONN_TIMEOUT_TICKS + 1);
  localparam logic [TW-1:0] TMR_LAST = TW'(CONN_TIMEOUT_TICKS - 1);

  tcp_state_t    state;
  close_t        close_r;
  logic          is_client;  // opened by connect
  logic          tcb_made;
  logic          tx_pend;    // builder still owns a request
  logic          ack_owed;
  logic          fin_sent;
  logic          ack_rcvd;
  logic          clear;      // internal return to closed
  logic [TW-1:0] conn_tmr;
  logic          conn_match;
  logic          user_drop;
  logic          in_progress;

  assign conn_match  = seg.hdr_v && (seg.dst_port == local_port) && (seg.src_port == tcb.port);
  assign user_drop   = force_fin || (is_client ? !connect : !listen);
  assign in_progress = !(state inside {st_closed, st_listen, st_established});
  assign established = (state == st_established);

  always_ff @(posedge clk) begin
    if (tcp_rst || clear) begin
      state       <= st_closed;
      close_r     <= close_active;
      is_client   <= 1'b0;
      tcb_made    <= 1'b0;
      tx_pend     <= 1'b0;
      ack_owed    <= 1'b0;
      fin_sent    <= 1'b0;
      ack_rcvd    <= 1'b0;
      clear       <= 1'b0;
      conn_tmr    <= '0;
      tcb         <= '0;
      tx_req      <= req_none;
      flush_queue <= 1'b0;
      connected   <= 1'b0;
    end else begin
      tx_req <= req_none;
      if (tx_done) tx_pend <= 1'b0;
      // progress timeout, stalled handshake or close
      if (!in_progress) conn_tmr <= '0;
      else if (conn_tmr == TMR_LAST) clear <= 1'b1;
      else conn_tmr <= conn_tmr + 1'b1;

      case (state)
        st_closed: begin
          if (listen) begin
            is_client <= 1'b0;
            state     <= st_listen;
          end else if (connect) begin
            is_client   <= 1'b1;
            tcb.ipv4    <= rem_ipv4;
            tcb.port    <= rem_port;
            tcb.loc_seq <= ISN_ACTIVE;
            tcb.loc_ack <= '0;
            tcb_made    <= 1'b1;
            if (tcb_made) begin  // SYN only once the tcb is written
              tx_req  <= req_syn;
              tx_pend <= 1'b1;
              state   <= st_wait_syn_ack;
            end
          end
        end
        st_listen: begin
          if (!listen) begin
            state <= st_closed;
          end else if (seg.hdr_v && seg.flags.bits.syn && (seg.dst_port == local_port)) begin
            tcb.ipv4    <= seg.ipv4;
            tcb.port    <= seg.src_port;
            tcb.loc_seq <= ISN_PASSIVE;
            tcb.loc_ack <= seg.seq + 32'd1;
            tcb.rem_seq <= seg.seq;
            tcb.rem_ack <= seg.ack;
            tx_req      <= req_syn_ack;
            tx_pend     <= 1'b1;
            state       <= st_syn_received;
          end
        end
        st_syn_received: begin
          if (conn_match && seg.flags.bits.ack && (seg.seq == tcb.rem_seq + 32'd1)) begin
            tcb.rem_seq <= seg.seq;
            tcb.rem_ack <= seg.ack;
            tcb.loc_seq <= seg.ack;
            state       <= st_established;
          end
        end
        st_wait_syn_ack: begin
          if (seg.hdr_v && seg.flags.bits.syn && seg.flags.bits.ack &&
              (seg.dst_port == local_port)) begin
            tcb.port    <= seg.src_port;
            tcb.rem_seq <= seg.seq;
            tcb.rem_ack <= seg.ack;
            tcb.loc_seq <= tcb.loc_seq + 32'd1;
            tcb.loc_ack <= seg.seq + 32'd1;
            tx_req      <= req_ack;
            tx_pend     <= 1'b1;
            state       <= st_established;
          end
        end
        st_established: begin
          connected <= 1'b1;
          //////////////////////////////////////////////////
          // receive, a FIN takes one sequence number
          if (seg.hdr_v && in_order) begin
            tcb.rem_seq <= seg.seq;
            tcb.rem_ack <= seg.ack;
            tcb.loc_ack <= tcb.loc_ack + 32'(seg.payload_len) + 32'(seg.flags.bits.fin);
          end
          //////////////////////////////////////////////////
          // transmit, queue data before a bare ACK
          if (!flush_queue && !tx_pend) begin
            if (queue_pend) begin
              tx_req      <= req_psh_ack;
              tx_seq      <= queue_seq;
              tx_len      <= queue_len;
              tcb.loc_seq <= queue_seq + 32'(queue_len);
              tx_pend     <= 1'b1;
              ack_owed    <= 1'b0;  // psh carries the ack too
            end else if (ack_owed) begin
              tx_req   <= req_ack;
              tx_pend  <= 1'b1;
              ack_owed <= 1'b0;
            end
          end
          if (ack_due) ack_owed <= 1'b1;
          //////////////////////////////////////////////////
          // close cause, then flush before the route
          if (!flush_queue) begin
            if (user_drop) begin
              flush_queue <= 1'b1;
              close_r     <= close_active;
            end else if (conn_match && seg.flags.bits.fin) begin
              flush_queue <= 1'b1;
              close_r     <= close_passive;
            end else if (conn_match && seg.flags.bits.rst) begin
              flush_queue <= 1'b1;
              close_r     <= close_reset;
            end
          end else if (queue_flushed) begin
            flush_queue <= 1'b0;
            case (close_r)
              close_active:  state <= st_send_fin;
              close_passive: state <= st_send_ack;
              default:       clear <= 1'b1;  // reset route sends nothing
            endcase
          end
        end
        st_send_fin: begin
          if (!fin_sent && !tx_pend) begin
            tx_req   <= req_fin_ack;
            tx_pend  <= 1'b1;
            fin_sent <= 1'b1;
          end
          if (conn_match && seg.flags.bits.ack) ack_rcvd <= 1'b1;
          if (conn_match && seg.flags.bits.fin && (ack_rcvd || seg.flags.bits.ack)) begin
            tcb.loc_ack <= tcb.loc_ack + 32'd1;  // remote FIN
            fin_sent    <= 1'b0;
            state       <= st_send_ack;
          end
        end
        st_send_ack: begin
          if (!tx_pend) begin
            tx_req  <= req_ack;
            tx_pend <= 1'b1;
            state   <= st_last_ack;
          end
        end
        st_last_ack: begin
          if (!fin_sent && !tx_pend) begin
            tx_req   <= req_fin_ack;
            tx_pend  <= 1'b1;
            fin_sent <= 1'b1;
          end
          if (conn_match && seg.flags.bits.ack && fin_sent) clear <= 1'b1;
        end
        default: state <= st_closed;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcp_tx_builder.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_tx_builder import tcp_pkg::*; (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic [15:0] local_port,
  input  tcb_t        tcb,
  input  tx_req_t     tx_req,
  input  logic [31:0] tx_seq,
  input  logic [15:0] tx_len,
  input  logic        tx_busy,
  tcp_seg_if.src      seg,
  output logic        tx_done
);

  tx_req_t    pend;       // request waiting for tx_busy to drop
  logic       send;
  logic       is_psh;
  tcp_flags_u flags_sel;

  assign send    = (pend != req_none) && !tx_busy;
  assign is_psh  = (pend == req_psh_ack);
  assign tx_done = seg.hdr_v;

  always_comb begin
    case (pend)
      req_syn:     flags_sel.word = FLAGS_SYN;
      req_syn_ack: flags_sel.word = FLAGS_SYN_ACK;
      req_psh_ack: flags_sel.word = FLAGS_PSH_ACK;
      req_fin_ack: flags_sel.word = FLAGS_FIN_ACK;
      default:     flags_sel.word = FLAGS_ACK;
    endcase
  end

  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      pend      <= req_none;
      seg.hdr_v <= 1'b0;
    end else begin
      seg.hdr_v <= send;  // one strobe per request
      if (tx_req != req_none) pend <= tx_req;
      else if (send) pend <= req_none;
    end
  end

  // tx_seq and tx_len stay put until the next psh request
  always_ff @(posedge clk) begin
    if (send) begin
      seg.ipv4        <= tcb.ipv4;
      seg.src_port    <= local_port;
      seg.dst_port    <= tcb.port;
      seg.flags       <= flags_sel;
      seg.seq         <= is_psh ? tx_seq : tcb.loc_seq;
      seg.ack         <= tcb.loc_ack;
      seg.payload_len <= is_psh ? tx_len : 16'd0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcp_engine_top.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_engine_top import tcp_pkg::*; #(
  parameter int CONN_TIMEOUT_TICKS = 10000000,
  parameter int ACK_TIMEOUT        = 125000
) (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic [15:0] local_port,
  input  logic [31:0] local_ipv4,
  // user control
  input  logic        listen,
  input  logic        connect,
  input  logic [31:0] rem_ipv4,
  input  logic [15:0] rem_port,
  input  logic        force_fin,
  // received header and payload bytes
  input  logic        rx_hdr_v,
  input  logic [31:0] rx_src_ip,
  input  logic [15:0] rx_src_port,
  input  logic [15:0] rx_dst_port,
  input  logic [31:0] rx_seq,
  input  logic [31:0] rx_ack,
  input  logic [8:0]  rx_flags,
  input  logic [15:0] rx_payload_len,
  input  logic        rx_v,
  input  logic [7:0]  rx_d,
  // transmit queue
  input  logic        queue_pend,
  input  logic [31:0] queue_seq,
  input  logic [15:0] queue_len,
  input  logic        queue_flushed,
  input  logic        tx_busy,
  // outgoing header
  output logic        tx_hdr_v,
  output logic [31:0] tx_dst_ip,
  output logic [15:0] tx_src_port,
  output logic [15:0] tx_dst_port,
  output logic [31:0] tx_seq,
  output logic [31:0] tx_ack,
  output logic [8:0]  tx_flags,
  output logic [15:0] tx_payload_len,
  output logic        vout,
  output logic [7:0]  dout,
  output logic        flush_queue,
  output logic        connected
);

  tcp_seg_if rx_seg ();
  tcp_seg_if tx_seg ();

  tcb_t        tcb;
  tx_req_t     tx_req;
  logic [31:0] req_seq;
  logic [15:0] req_len;
  logic        in_order;
  logic        ack_due;
  logic        tx_done;
  logic        established;

  //////////////////////////////////////////////////
  // receive side
  tcp_rx_filter rx_filter_i (
    .clk,
    .tcp_rst,
    .rx_hdr_v,
    .rx_src_ip,
    .rx_src_port,
    .rx_dst_port,
    .rx_seq,
    .rx_ack,
    .rx_flags,
    .rx_payload_len,
    .rx_v,
    .rx_d,
    .local_port,
    .tcb_port    (tcb.port),
    .tcb_loc_ack (tcb.loc_ack),
    .established,
    .seg         (rx_seg.src),
    .in_order,
    .vout,
    .dout
  );

  tcp_ack_timer #(
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) ack_timer_i (
    .clk,
    .tcp_rst,
    .established,
    .seg      (rx_seg.dst),
    .in_order,
    .ack_due
  );

  //////////////////////////////////////////////////
  // connection control
  tcp_conn_fsm #(
    .CONN_TIMEOUT_TICKS (CONN_TIMEOUT_TICKS)
  ) conn_fsm_i (
    .clk,
    .tcp_rst,
    .listen,
    .connect,
    .force_fin,
    .rem_ipv4,
    .rem_port,
    .local_port,
    .seg           (rx_seg.dst),
    .in_order,
    .ack_due,
    .queue_pend,
    .queue_seq,
    .queue_len,
    .queue_flushed,
    .tx_done,
    .tcb,
    .tx_req,
    .tx_seq        (req_seq),
    .tx_len        (req_len),
    .flush_queue,
    .connected,
    .established
  );

  //////////////////////////////////////////////////
  // transmit side
  tcp_tx_builder tx_builder_i (
    .clk,
    .tcp_rst,
    .local_port,
    .tcb,
    .tx_req,
    .tx_seq  (req_seq),
    .tx_len  (req_len),
    .tx_busy,
    .seg     (tx_seg.src),
    .tx_done
  );

  assign tx_hdr_v       = tx_seg.hdr_v;
  assign tx_dst_ip      = tx_seg.ipv4;
  assign tx_src_port    = tx_seg.src_port;
  assign tx_dst_port    = tx_seg.dst_port;
  assign tx_seq         = tx_seg.seq;
  assign tx_ack         = tx_seg.ack;
  assign tx_flags       = tx_seg.flags.word;
  assign tx_payload_len = tx_seg.payload_len;

endmodule

`default_nettype wire

// File: dv/tcp_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_checker #(
  parameter int          ACK_TIMEOUT = 40,
  parameter int          CLK_NS      = 4,
  parameter logic [15:0] LOCAL_PORT  = 16'h1234,
  parameter logic [15:0] REM_PORT    = 16'h5000,
  parameter logic [31:0] REM_IP      = 32'h0a000002
) (
  input  logic        clk,
  input  logic        tx_hdr_v,
  input  logic [31:0] tx_dst_ip,
  input  logic [15:0] tx_src_port,
  input  logic [15:0] tx_dst_port,
  input  logic [31:0] tx_seq,
  input  logic [31:0] tx_ack,
  input  logic [8:0]  tx_flags,
  input  logic [15:0] tx_payload_len,
  input  logic        vout,
  input  logic [7:0]  dout
);

  logic [89:0] seg_q [$];  // {late, flags, seq, ack, len}
  logic [7:0]  byte_q [$];
  int          errors = 0;
  int          seen = 0;   // tx segments observed so far
  time         last_data = 0;

  task automatic expect_seg(input logic late, input logic [8:0] flags,
                            input logic [31:0] seq, input logic [31:0] ack,
                            input logic [15:0] len);
    seg_q.push_back({late, flags, seq, ack, len});
  endtask

  task automatic expect_byte(input logic [7:0] b);
    byte_q.push_back(b);
  endtask

  task automatic note_data();
    last_data = $time;  // header of the latest accepted data
  endtask

  function automatic int pending();
    return byte_q.size();
  endfunction

  task automatic value_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic other_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  //////////////////////////////////////////////////
  // compare outputs in arrival order
  always @(posedge clk) begin
    logic [89:0] e;
    logic [7:0]  b;
    if (tx_hdr_v === 1'b1) begin
      seen++;
      if (seg_q.size() == 0) begin
        value_error($sformatf("unexpected segment flags %03h seq %08h ack %08h",
                              tx_flags, tx_seq, tx_ack));
      end else begin
        e = seg_q.pop_front();
        if ({tx_flags, tx_seq, tx_ack, tx_payload_len} !== e[88:0]) begin
          value_error($sformatf({"segment %0d got %03h %08h %08h len %0d, ",
                                 "expected %03h %08h %08h len %0d"},
                                seen, tx_flags, tx_seq, tx_ack, tx_payload_len,
                                e[88:80], e[79:48], e[47:16], e[15:0]));
        end
        if (tx_dst_ip !== REM_IP || tx_src_port !== LOCAL_PORT ||
            tx_dst_port !== REM_PORT) begin
          value_error($sformatf({"segment %0d addressed %08h port %04h to %04h, ",
                                 "expected %08h port %04h to %04h"},
                                seen, tx_dst_ip, tx_src_port, tx_dst_port,
                                REM_IP, LOCAL_PORT, REM_PORT));
        end
        if (e[89] && ($time - last_data < ACK_TIMEOUT * CLK_NS))
          value_error("bare ACK came before the ack timeout");
      end
    end
    if (vout === 1'b1) begin
      if (byte_q.size() == 0) begin
        value_error($sformatf("unexpected payload byte %02h", dout));
      end else begin
        b = byte_q.pop_front();
        if (dout !== b) value_error($sformatf("byte %02h, expected %02h", dout, b));
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_tcp_engine.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tcp_engine;

  localparam int          CLK_NS     = 4;
  localparam int          CONN_TICKS = 200;
  localparam int          ACK_TICKS  = 40;
  localparam logic [15:0] LOCAL_PORT = 16'h1234;
  localparam logic [15:0] REM_PORT   = 16'h5000;
  localparam logic [31:0] REM_IP     = 32'h0a000002;

  logic clk, tcp_rst;
  logic [15:0] local_port;
  logic [31:0] local_ipv4;
  logic listen, connect, force_fin;
  logic [31:0] rem_ipv4;
  logic [15:0] rem_port;
  logic rx_hdr_v;
  logic [31:0] rx_src_ip, rx_seq, rx_ack;
  logic [15:0] rx_src_port, rx_dst_port, rx_payload_len;
  logic [8:0] rx_flags;
  logic rx_v;
  logic [7:0] rx_d;
  logic queue_pend, queue_flushed, tx_busy;
  logic [31:0] queue_seq;
  logic [15:0] queue_len;
  logic tx_hdr_v;
  logic [31:0] tx_dst_ip, tx_seq, tx_ack;
  logic [15:0] tx_src_port, tx_dst_port, tx_payload_len;
  logic [8:0] tx_flags;
  logic vout, flush_queue, connected;
  logic [7:0] dout;

  logic [95:0] golden [0:127];  // op, f, a, b, len
  logic [95:0] rec;
  logic [31:0] rnd, busy_rnd;
  logic        busy_mode, loaded;
  int n_rec, exp_n, cur_test, err_mark, tests_ok, tests_bad, r;

  tcp_engine_top #(
    .CONN_TIMEOUT_TICKS (CONN_TICKS),
    .ACK_TIMEOUT        (ACK_TICKS)
  ) dut_i (.*);

  tcp_checker #(
    .ACK_TIMEOUT (ACK_TICKS),
    .CLK_NS      (CLK_NS),
    .LOCAL_PORT  (LOCAL_PORT),
    .REM_PORT    (REM_PORT),
    .REM_IP      (REM_IP)
  ) chk_i (
    .clk, .tx_hdr_v, .tx_dst_ip, .tx_src_port, .tx_dst_port, .tx_seq, .tx_ack,
    .tx_flags, .tx_payload_len, .vout, .dout
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_gap();
    int n;
    rnd = xorshift(rnd);
    n = 2 + int'(rnd[1:0]);
    repeat (n) step();
  endtask

  // f[9] picks a wrong source port, f[10] marks in-order data
  task automatic send_seg(input logic [11:0] f, input logic [31:0] seq,
                          input logic [31:0] ack, input logic [15:0] len);
    int i;
    int last;
    last = (len == 0) ? 1 : int'(len);
    for (i = 0; i < last; i++) begin
      step();
      rx_hdr_v       = (i == 0);
      rx_src_port    = f[9] ? (REM_PORT ^ 16'h0001) : REM_PORT;
      rx_seq         = seq;
      rx_ack         = ack;
      rx_flags       = f[8:0];
      rx_payload_len = len;
      if (i == 0 && f[10]) chk_i.note_data();
      if (i < int'(len)) begin
        rnd  = xorshift(rnd);
        rx_v = 1'b1;
        rx_d = rnd[7:0];
        if (f[10]) chk_i.expect_byte(rnd[7:0]);
      end else begin
        rx_v = 1'b0;
      end
    end
    step();
    rx_hdr_v = 1'b0;
    rx_v     = 1'b0;
  endtask

  task automatic check_connected(input logic level);
    int i;
    i = 0;
    while (connected !== level && i < 10) begin
      step();
      i++;
    end
    if (connected !== level)
      chk_i.value_error($sformatf("connected is %b, expected %b", connected, level));
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // random tx_busy pulses while enabled
  initial begin
    forever begin
      @(posedge clk);
      #1;
      busy_rnd = xorshift(busy_rnd);
      tx_busy  = busy_mode & busy_rnd[0];
    end
  end

  //////////////////////////////////////////////////
  // golden-file driven stimulus
  initial begin
    tcp_rst = 1'b1;
    local_port = LOCAL_PORT;
    local_ipv4 = 32'h0a000001;
    listen = 1'b0;
    connect = 1'b0;
    force_fin = 1'b0;
    rem_ipv4 = REM_IP;
    rem_port = REM_PORT;
    rx_hdr_v = 1'b0;
    rx_src_ip = REM_IP;
    rx_src_port = REM_PORT;
    rx_dst_port = LOCAL_PORT;
    rx_seq = '0;
    rx_ack = '0;
    rx_flags = '0;
    rx_payload_len = '0;
    rx_v = 1'b0;
    rx_d = '0;
    queue_pend = 1'b0;
    queue_seq = '0;
    queue_len = '0;
    queue_flushed = 1'b0;
    tx_busy = 1'b0;
    busy_mode = 1'b0;
    loaded = 1'b0;
    rnd = 32'hf0ed;
    busy_rnd = xorshift(32'hf0ed);
    exp_n = 0;
    cur_test = 1;
    err_mark = 0;
    tests_ok = 0;
    tests_bad = 0;
    $readmemh("dv/tcp_golden.txt", golden);
    n_rec = 0;
    while (n_rec < 128 && golden[n_rec][95:92] != 4'hf) n_rec++;
    for (r = 0; r < n_rec; r++) begin  // expected segments go in up front
      rec = golden[r];
      if (rec[95:92] == 4'h4)
        chk_i.expect_seg(rec[90], rec[88:80], rec[79:48], rec[47:16], rec[15:0]);
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1 tcp_rst = 1'b0;

    for (r = 0; r < n_rec; r++) begin
      rec = golden[r];
      case (rec[95:92])
        4'h0: begin  // end of test
          if (chk_i.errors == err_mark) tests_ok++;
          else tests_bad++;
          $display("test %0d: %s, %0d errors", rec[91:80],
                   (chk_i.errors == err_mark) ? "ok" : "bad", chk_i.errors - err_mark);
          err_mark = chk_i.errors;
          cur_test++;
        end
        4'h1: begin
          idle_gap();
          listen    = rec[80];
          connect   = rec[81];
          force_fin = rec[82];
        end
        4'h2: begin
          idle_gap();
          send_seg(rec[91:80], rec[79:48], rec[47:16], rec[15:0]);
        end
        4'h3: begin
          idle_gap();
          queue_pend = 1'b1;
          queue_seq  = rec[79:48];
          queue_len  = rec[15:0];
          step();
          queue_pend = 1'b0;
        end
        4'h4: begin
          exp_n++;
          while (chk_i.seen < exp_n) step();
        end
        4'h5: begin
          while (flush_queue !== 1'b1) step();
          step();
          queue_flushed = 1'b1;
          step();
          queue_flushed = 1'b0;
        end
        4'h6: repeat (int'(rec[79:48])) step();
        4'h7: check_connected(rec[80]);
        4'h8: busy_mode = rec[80];
        default: chk_i.other_error($sformatf("bad golden record %0d", r));
      endcase
    end
    repeat (10) step();
    if (chk_i.pending() != 0)
      chk_i.other_error($sformatf("%0d expected bytes never appeared on dout", chk_i.pending()));
    $display("tests: %0d ok, %0d bad, %0d errors in total", tests_ok, tests_bad, chk_i.errors);
    if (tests_bad == 0 && chk_i.errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog sized from the record count
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(n_rec) * (CONN_TICKS + 100) * CLK_NS;
    #(limit_ns);
    $display("timeout in test %0d: expected tx segment %0d never arrived",
             cur_test, chk_i.seen + 1);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tcp_golden.txt
// op+f | a (seq) | b (ack) | len ; op 0 end test, 1 ctrl, 2 rx, 3 queue, 4 expect tx,
// 5 flush, 6 wait a cycles, 7 connected=f[0], 8 tx_busy mode, f end; f[10] data/late, f[9] bad port
1001_00000000_00000000_0000
2002_10000000_00000000_0000
4012_feadabba_10000001_0000
2010_10000001_feadabbb_0000
7001_00000000_00000000_0000
0001_00000000_00000000_0000
2418_10000001_feadabbb_0004
2018_10000001_feadabbb_0003
2218_10000005_feadabbb_0002
2418_10000005_feadabbb_0003
4410_feadabbb_10000008_0000
0002_00000000_00000000_0000
3000_feadabbb_00000000_0008
4018_feadabbb_10000008_0008
8001_00000000_00000000_0000
3000_feadabc3_00000000_0005
4018_feadabc3_10000008_0005
8000_00000000_00000000_0000
0003_00000000_00000000_0000
2011_10000008_feadabc8_0000
5000_00000000_00000000_0000
4010_feadabc8_10000009_0000
4011_feadabc8_10000009_0000
2010_10000009_feadabc9_0000
7000_00000000_00000000_0000
0004_00000000_00000000_0000
1000_00000000_00000000_0000
1002_00000000_00000000_0000
4002_abbadead_00000000_0000
2012_20000000_abbadeae_0000
4010_abbadeae_20000001_0000
7001_00000000_00000000_0000
1000_00000000_00000000_0000
5000_00000000_00000000_0000
4011_abbadeae_20000001_0000
2010_20000001_abbadeaf_0000
2011_20000001_abbadeaf_0000
4010_abbadeae_20000002_0000
4011_abbadeae_20000002_0000
2010_20000002_abbadeaf_0000
7000_00000000_00000000_0000
0005_00000000_00000000_0000
1001_00000000_00000000_0000
2002_30000000_00000000_0000
4012_feadabba_30000001_0000
2010_30000001_feadabbb_0000
7001_00000000_00000000_0000
2004_30000001_feadabbb_0000
5000_00000000_00000000_0000
7000_00000000_00000000_0000
2002_40000000_00000000_0000
4012_feadabba_40000001_0000
6000_000000d2_00000000_0000
2002_50000000_00000000_0000
4012_feadabba_50000001_0000
0006_00000000_00000000_0000
f000_00000000_00000000_0000

// File: src.f
verilog/tcp_pkg.sv
verilog/tcp_seg_if.sv
verilog/tcp_rx_filter.sv
verilog/tcp_ack_timer.sv
verilog/tcp_conn_fsm.sv
verilog/tcp_tx_builder.sv
verilog/tcp_engine_top.sv
dv/tcp_checker.sv
dv/tb_tcp_engine.sv

// File: Bender.yml
package:
  name: tcp_engine

sources:
  - files:
      - verilog/tcp_pkg.sv
      - verilog/tcp_seg_if.sv
      - verilog/tcp_rx_filter.sv
      - verilog/tcp_ack_timer.sv
      - verilog/tcp_conn_fsm.sv
      - verilog/tcp_tx_builder.sv
      - verilog/tcp_engine_top.sv
  - target: test
    files:
      - dv/tcp_checker.sv
      - dv/tb_tcp_engine.sv
